// ==== verilog/pipePkg.sv ====
// Pipeline shared definitions
`default_nettype none

package pipePkg;

    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    localparam logic [5:0] functAddu = 6'h21;
    localparam logic [5:0] functSubu = 6'h23;
    localparam logic [5:0] functMul = 6'h18; // Low word of the product goes to rd.

    typedef enum logic [2:0] {aluAdd, aluSub, aluOr, aluMul, aluPass} aluOpT;

    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdWb = 2'b01,
        fwdMem = 2'b10
    } fwdSelT;

    typedef struct packed {
        logic valid;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] writeReg;
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic useImm;
        aluOpT aluOp;
        logic [31:0] rsData;
        logic [31:0] rtData;
        logic [31:0] imm;
    } decExT;

    typedef struct packed {
        logic valid;
        logic [4:0] writeReg;
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic [31:0] result;
        logic [31:0] storeData;
    } exMemT;

    typedef struct packed {
        logic valid;
        logic [4:0] writeReg;
        logic regWrite;
        logic [31:0] wbData;
    } memWbT;

endpackage

`default_nettype wire

// ==== verilog/pipeReg.sv ====
// Pipeline stage register
`timescale 1ns/10ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = pipePkg::memWbT
) (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic flush,
    input  payloadT d,
    output payloadT q
);

    payloadT bubble;

    always_comb
    begin
        bubble = d;
        bubble.valid = 1'b0; // Payload kept, only the slot is emptied.
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            q <= '0;
        else if (!stall)
            q <= flush ? bubble : d;
    end

endmodule

`default_nettype wire

// ==== verilog/decodeStage.sv ====
// Instruction decode and register file
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
    input  logic clk,
    input  logic rstN,
    input  logic instValid,
    input  logic [31:0] instData,
    input  logic wrEn,
    input  logic [4:0] wrReg,
    input  logic [31:0] wrData,
    output logic [4:0] rs,
    output logic [4:0] rt,
    output pipePkg::decExT decEx
);

    logic [31:0] regFile [32];
    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rd;
    logic [15:0] imm16;
    logic known;

    assign opcode = instData[31:26];
    assign rs = instData[25:21];
    assign rt = instData[20:16];
    assign rd = instData[15:11];
    assign funct = instData[5:0];
    assign imm16 = instData[15:0];

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 32; i++)
                regFile[i] <= '0;
        end
        else if (wrEn && wrReg != 5'd0)
        begin
            regFile[wrReg] <= wrData;
        end
    end

    // A write from W in this same cycle is seen by the read.
    function automatic logic [31:0] readReg(input logic [4:0] idx);
        logic [31:0] value;
        value = regFile[idx];
        if (idx == 5'd0)
            value = '0;
        else if (wrEn && wrReg == idx)
            value = wrData;
        return value;
    endfunction

    always_comb
    begin
        decEx = '0;
        known = 1'b1;
        decEx.rs = rs;
        decEx.rt = rt;
        decEx.rsData = readReg(rs);
        decEx.rtData = readReg(rt);
        decEx.writeReg = rt;
        decEx.aluOp = pipePkg::aluAdd;
        decEx.imm = {{16{imm16[15]}}, imm16};
        case (opcode)
            pipePkg::opRtype:
            begin
                decEx.writeReg = rd;
                decEx.regWrite = 1'b1;
                case (funct)
                    pipePkg::functAddu: decEx.aluOp = pipePkg::aluAdd;
                    pipePkg::functSubu: decEx.aluOp = pipePkg::aluSub;
                    pipePkg::functMul: decEx.aluOp = pipePkg::aluMul;
                    default: known = 1'b0;
                endcase
            end
            pipePkg::opOri:
            begin
                decEx.regWrite = 1'b1;
                decEx.useImm = 1'b1;
                decEx.aluOp = pipePkg::aluOr;
                decEx.imm = {16'd0, imm16}; // Logical immediate is zero extended.
            end
            pipePkg::opLw:
            begin
                decEx.regWrite = 1'b1;
                decEx.memRead = 1'b1;
                decEx.useImm = 1'b1;
            end
            pipePkg::opSw:
            begin
                decEx.memWrite = 1'b1;
                decEx.useImm = 1'b1;
            end
            default: known = 1'b0;
        endcase
        if (!known)
        begin
            decEx.regWrite = 1'b0;
            decEx.aluOp = pipePkg::aluPass;
        end
        decEx.valid = instValid && known;
    end

endmodule

`default_nettype wire

// ==== verilog/hazardUnit.sv ====
// Forwarding and stall control
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  logic [4:0] rsD,
    input  logic [4:0] rtD,
    input  pipePkg::decExT decEx,
    input  pipePkg::exMemT exMem,
    input  pipePkg::memWbT memWb,
    input  logic multBusy,
    output logic stallF,
    output logic stallD,
    output logic stallE,
    output logic flushE,
    output logic flushM,
    output pipePkg::fwdSelT forwardAE,
    output pipePkg::fwdSelT forwardBE
);

    logic memWrites;
    logic wbWrites;
    logic loadUse;

    assign memWrites = exMem.valid && exMem.regWrite;
    assign wbWrites = memWb.valid && memWb.regWrite;

    // The younger result in M wins over the one in W.
    function automatic pipePkg::fwdSelT fwdSelect(input logic [4:0] srcReg);
        pipePkg::fwdSelT sel;
        sel = pipePkg::fwdNone;
        if (srcReg != 5'd0 && memWrites && srcReg == exMem.writeReg)
            sel = pipePkg::fwdMem;
        else if (srcReg != 5'd0 && wbWrites && srcReg == memWb.writeReg)
            sel = pipePkg::fwdWb;
        return sel;
    endfunction

    always_comb
    begin
        forwardAE = fwdSelect(decEx.rs);
        forwardBE = fwdSelect(decEx.rt);
    end

    // A load in E cannot feed D until it reaches W.
    assign loadUse = decEx.valid && decEx.memRead && decEx.writeReg != 5'd0
        && (decEx.writeReg == rsD || decEx.writeReg == rtD);

    assign stallF = loadUse || multBusy;
    assign stallD = loadUse || multBusy;
    assign stallE = multBusy; // Mul holds E until its product is in.
    assign flushE = loadUse;
    assign flushM = multBusy;

endmodule

`default_nettype wire

// ==== verilog/multiplier.sv ====
// Iterative shift-add multiplier
`timescale 1ns/10ps
`default_nettype none

module multiplier #(
    parameter int multBits = 8
) (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic productValid,
    output logic [31:0] product
);

    localparam int iters = 32 / multBits;

    logic running;
    logic [5:0] count;
    logic [31:0] aShift;
    logic [31:0] bShift;
    logic [31:0] acc;

    function automatic logic [31:0] partial(input logic [31:0] x, input logic [31:0] y);
        return x * 32'(y[multBits-1:0]);
    endfunction

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            running <= 1'b0;
            count <= '0;
            productValid <= 1'b0;
        end
        else
        begin
            productValid <= 1'b0;
            if (running)
            begin
                count <= count + 6'd1;
                if (count == 6'(iters - 1))
                begin
                    running <= 1'b0;
                    productValid <= 1'b1;
                end
            end
            else if (start)
            begin
                running <= 1'b1;
                count <= 6'd1; // The first slice is added at start.
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (running)
        begin
            acc <= acc + partial(aShift, bShift);
            aShift <= aShift << multBits;
            bShift <= bShift >> multBits;
        end
        else if (start)
        begin
            acc <= partial(a, b);
            aShift <= a << multBits;
            bShift <= b >> multBits;
        end
    end

    assign product = acc;

endmodule

`default_nettype wire

// ==== verilog/execStage.sv ====
// Execute stage
`timescale 1ns/10ps
`default_nettype none

module execStage #(
    parameter int multBits = 8
) (
    input  logic clk,
    input  logic rstN,
    input  pipePkg::decExT decEx,
    input  pipePkg::fwdSelT forwardAE,
    input  pipePkg::fwdSelT forwardBE,
    input  logic [31:0] memResult,
    input  logic [31:0] wbData,
    output pipePkg::exMemT exMem,
    output logic multBusy
);

    logic [31:0] srcA;
    logic [31:0] rtVal;
    logic [31:0] srcB;
    logic [31:0] product;
    logic isMul;
    logic start;
    logic started;
    logic productValid;

    function automatic logic [31:0] fwdMux(input pipePkg::fwdSelT sel,
                                           input logic [31:0] regVal,
                                           input logic [31:0] memVal,
                                           input logic [31:0] wbVal);
        case (sel)
            pipePkg::fwdMem: return memVal;
            pipePkg::fwdWb: return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA = fwdMux(forwardAE, decEx.rsData, memResult, wbData);
    assign rtVal = fwdMux(forwardBE, decEx.rtData, memResult, wbData);
    assign srcB = decEx.useImm ? decEx.imm : rtVal;

    // Operands are latched by the multiplier while forwarding is still valid.
    assign isMul = decEx.valid && decEx.aluOp == pipePkg::aluMul;
    assign start = isMul && !started;
    assign multBusy = isMul && !productValid;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            started <= 1'b0;
        else if (productValid)
            started <= 1'b0;
        else if (start)
            started <= 1'b1;
    end

    multiplier #(.multBits(multBits)) mult (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .a(srcA),
        .b(srcB),
        .productValid(productValid),
        .product(product)
    );

    always_comb
    begin
        exMem.valid = decEx.valid;
        exMem.writeReg = decEx.writeReg;
        exMem.regWrite = decEx.regWrite;
        exMem.memRead = decEx.memRead;
        exMem.memWrite = decEx.memWrite;
        exMem.storeData = rtVal;
        case (decEx.aluOp)
            pipePkg::aluAdd: exMem.result = srcA + srcB; // Also the load/store address.
            pipePkg::aluSub: exMem.result = srcA - srcB;
            pipePkg::aluOr: exMem.result = srcA | srcB;
            pipePkg::aluMul: exMem.result = product;
            default: exMem.result = srcB;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/memStage.sv ====
// Data memory stage
`timescale 1ns/10ps
`default_nettype none

module memStage #(
    parameter int memWords = 64
) (
    input  logic clk,
    input  logic rstN,
    input  pipePkg::exMemT exMem,
    output pipePkg::memWbT memWb
);

    localparam int addrBits = $clog2(memWords);

    logic [31:0] dataMem [memWords];
    logic [addrBits-1:0] addr;

    assign addr = exMem.result[2 +: addrBits]; // Word address, byte offset dropped.

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < memWords; i++)
                dataMem[i] <= '0;
        end
        else if (exMem.valid && exMem.memWrite)
        begin
            dataMem[addr] <= exMem.storeData;
        end
    end

    always_comb
    begin
        memWb.valid = exMem.valid;
        memWb.writeReg = exMem.writeReg;
        memWb.regWrite = exMem.regWrite;
        memWb.wbData = exMem.memRead ? dataMem[addr] : exMem.result;
    end

endmodule

`default_nettype wire

// ==== verilog/pipeCore.sv ====
// Five stage pipeline core
`timescale 1ns/10ps
`default_nettype none

module pipeCore #(
    parameter int memWords = 64,
    parameter int multBits = 8
) (
    input  logic clk,
    input  logic rstN,
    input  logic instValid,
    input  logic [31:0] instData,
    output logic instReady,
    output logic wbValid,
    output logic [4:0] wbReg,
    output logic [31:0] wbData
);

    typedef struct packed {
        logic valid;
        logic [31:0] inst;
    } fetchT;

    fetchT fetchIn;
    fetchT fetchOut;
    pipePkg::decExT decExD;
    pipePkg::decExT decExE;
    pipePkg::exMemT exMemE;
    pipePkg::exMemT exMemM;
    pipePkg::memWbT memWbM;
    pipePkg::memWbT memWbW;
    pipePkg::fwdSelT forwardAE;
    pipePkg::fwdSelT forwardBE;
    logic [4:0] rsD;
    logic [4:0] rtD;
    logic stallF;
    logic stallD;
    logic stallE;
    logic flushE;
    logic flushM;
    logic multBusy;
    logic wrEn;

    assign instReady = !stallF;
    assign fetchIn = {instValid, instData}; // No transfer means a bubble into D.
    assign wrEn = memWbW.valid && memWbW.regWrite && memWbW.writeReg != 5'd0;
    assign wbValid = wrEn;
    assign wbReg = memWbW.writeReg;
    assign wbData = memWbW.wbData;

    pipeReg #(.payloadT(fetchT)) fD (
        .clk(clk), .rstN(rstN), .stall(stallD), .flush(1'b0), .d(fetchIn), .q(fetchOut)
    );

    decodeStage decode (
        .clk(clk),
        .rstN(rstN),
        .instValid(fetchOut.valid),
        .instData(fetchOut.inst),
        .wrEn(wrEn),
        .wrReg(memWbW.writeReg),
        .wrData(memWbW.wbData),
        .rs(rsD),
        .rt(rtD),
        .decEx(decExD)
    );

    pipeReg #(.payloadT(pipePkg::decExT)) dE (
        .clk(clk), .rstN(rstN), .stall(stallE), .flush(flushE), .d(decExD), .q(decExE)
    );

    hazardUnit hazard (
        .rsD(rsD),
        .rtD(rtD),
        .decEx(decExE),
        .exMem(exMemM),
        .memWb(memWbW),
        .multBusy(multBusy),
        .stallF(stallF),
        .stallD(stallD),
        .stallE(stallE),
        .flushE(flushE),
        .flushM(flushM),
        .forwardAE(forwardAE),
        .forwardBE(forwardBE)
    );

    execStage #(.multBits(multBits)) exec (
        .clk(clk),
        .rstN(rstN),
        .decEx(decExE),
        .forwardAE(forwardAE),
        .forwardBE(forwardBE),
        .memResult(exMemM.result),
        .wbData(memWbW.wbData),
        .exMem(exMemE),
        .multBusy(multBusy)
    );

    pipeReg #(.payloadT(pipePkg::exMemT)) eM (
        .clk(clk), .rstN(rstN), .stall(1'b0), .flush(flushM), .d(exMemE), .q(exMemM)
    );

    memStage #(.memWords(memWords)) memory (
        .clk(clk),
        .rstN(rstN),
        .exMem(exMemM),
        .memWb(memWbM)
    );

    pipeReg #(.payloadT(pipePkg::memWbT)) mW (
        .clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(memWbM), .q(memWbW)
    );

endmodule

`default_nettype wire

// ==== bench/hazardUnit_props.sv ====
// Hazard unit assertions
`timescale 1ns/10ps
`default_nettype none

module hazardUnitProps (
    input logic clk,
    input logic rstN,
    input pipePkg::decExT decEx,
    input logic stallF,
    input logic stallD,
    input logic stallE,
    input logic flushE,
    input pipePkg::fwdSelT forwardAE,
    input pipePkg::fwdSelT forwardBE
);

    int failCount = 0; // Read by the testbench at the end of the run.

    // Register 0 is hardwired to zero, so no stage may feed it.
    rsZeroNoFwd: assert property (@(posedge clk) disable iff (!rstN)
        decEx.rs == 5'd0 |-> forwardAE == pipePkg::fwdNone)
    else
    begin
        $error("forwardAE selects a forwarding source for r0");
        failCount++;
    end

    rtZeroNoFwd: assert property (@(posedge clk) disable iff (!rstN)
        decEx.rt == 5'd0 |-> forwardBE == pipePkg::fwdNone)
    else
    begin
        $error("forwardBE selects a forwarding source for r0");
        failCount++;
    end

    stallOrder: assert property (@(posedge clk) disable iff (!rstN)
        stallD |-> stallF)
    else
    begin
        $error("stallD is high while stallF is low");
        failCount++;
    end

    // A held E stage cannot also be emptied.
    holdOrFlush: assert property (@(posedge clk) disable iff (!rstN)
        !(flushE && stallE))
    else
    begin
        $error("flushE and stallE are high in the same cycle");
        failCount++;
    end

endmodule

// The core wires the hazard unit's ports next to the clock.
bind pipeCore hazardUnitProps hazardProps (
    .clk(clk),
    .rstN(rstN),
    .decEx(decExE),
    .stallF(stallF),
    .stallD(stallD),
    .stallE(stallE),
    .flushE(flushE),
    .forwardAE(forwardAE),
    .forwardBE(forwardBE)
);

`default_nettype wire

// ==== bench/pipeCoreTb.sv ====
// Pipeline core testbench
`timescale 1ns/10ps
`default_nettype none

module pipeCoreTb;

    localparam int numInsts = 400;
    localparam int readyTimeout = 50;
    localparam int drainTimeout = 200;

    localparam logic [2:0] kAddu = 3'd0;
    localparam logic [2:0] kSubu = 3'd1;
    localparam logic [2:0] kOri = 3'd2;
    localparam logic [2:0] kLw = 3'd3;
    localparam logic [2:0] kSw = 3'd4;
    localparam logic [2:0] kMul = 3'd5;

    typedef struct packed {
        logic [15:0] seq;
        logic [2:0] kind;
        logic [4:0] regNum;
        logic [31:0] data;
    } retireT;

    logic clk;
    logic rstN;
    logic instValid;
    logic [31:0] instData;
    logic instReady;
    logic wbValid;
    logic [4:0] wbReg;
    logic [31:0] wbData;

    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [64];
    retireT expected [$];
    int valueErrors;
    int otherErrors;
    int extraRetires;
    bit sawStall;
    bit timedOut;

    pipeCore #(.memWords(64), .multBits(8)) i_dut (
        .clk(clk),
        .rstN(rstN),
        .instValid(instValid),
        .instData(instData),
        .instReady(instReady),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData)
    );

    always #2 clk = ~clk;

    function automatic string kindName(input logic [2:0] kind);
        case (kind)
            kAddu: return "addu";
            kSubu: return "subu";
            kOri: return "ori";
            kLw: return "lw";
            kSw: return "sw";
            default: return "mul";
        endcase
    endfunction

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] funct);
        return {pipePkg::opRtype, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Only r0..r7 are used so that dependencies come often.
    task automatic makeInst(output logic [31:0] inst, output logic [2:0] kind);
        int pick;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [15:0] imm;
        logic [15:0] wordOffset;
        pick = $urandom % 100;
        rs = 5'($urandom % 8);
        rt = 5'($urandom % 8);
        rd = 5'($urandom % 8);
        imm = 16'($urandom);
        wordOffset = 16'(($urandom % 16) * 4);
        if (pick < 20)
        begin
            kind = kAddu;
            inst = rType(rs, rt, rd, pipePkg::functAddu);
        end
        else if (pick < 35)
        begin
            kind = kSubu;
            inst = rType(rs, rt, rd, pipePkg::functSubu);
        end
        else if (pick < 55)
        begin
            kind = kOri;
            inst = iType(pipePkg::opOri, rs, rt, imm);
        end
        else if (pick < 70)
        begin
            kind = kLw;
            inst = iType(pipePkg::opLw, 5'd0, rt, wordOffset); // Base r0 keeps it in 16 words.
        end
        else if (pick < 85)
        begin
            kind = kSw;
            inst = iType(pipePkg::opSw, 5'd0, rt, wordOffset);
        end
        else
        begin
            kind = kMul;
            inst = rType(rs, rt, rd, pipePkg::functMul);
        end
    endtask

    // ISA model, one instruction at a time in acceptance order.
    task automatic runModel(input logic [31:0] inst, input logic [2:0] kind, input int seq);
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] dest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] result;
        logic writes;
        retireT entry;
        rs = inst[25:21];
        rt = inst[20:16];
        a = modelRegs[rs];
        b = modelRegs[rt];
        addr = a + {{16{inst[15]}}, inst[15:0]};
        writes = 1'b1;
        dest = rt;
        result = '0;
        case (inst[31:26])
            pipePkg::opRtype:
            begin
                dest = inst[15:11];
                case (inst[5:0])
                    pipePkg::functAddu: result = a + b;
                    pipePkg::functSubu: result = a - b;
                    default: result = a * b; // Low word only.
                endcase
            end
            pipePkg::opOri: result = a | {16'd0, inst[15:0]};
            pipePkg::opLw: result = modelMem[addr[7:2]];
            default:
            begin
                writes = 1'b0;
                modelMem[addr[7:2]] = b;
            end
        endcase
        if (writes && dest != 5'd0)
        begin
            modelRegs[dest] = result;
            entry.seq = 16'(seq);
            entry.kind = kind;
            entry.regNum = dest;
            entry.data = result;
            expected.push_back(entry);
        end
    endtask

    // Holds the instruction on the bus until the core takes it.
    task automatic sendInst(input logic [31:0] inst, output bit accepted);
        int waited;
        waited = 0;
        accepted = 1'b0;
        instValid <= 1'b1;
        instData <= inst;
        while (!accepted && waited < readyTimeout)
        begin
            @(posedge clk);
            if (instReady)
                accepted = 1'b1;
            else
            begin
                sawStall = 1'b1;
                waited++;
            end
        end
    endtask

    always @(posedge clk)
    begin
        retireT front;
        if (rstN && wbValid)
        begin
            if (expected.size() == 0)
            begin
                $display("Unexpected retire of r%0d = %08h with nothing pending", wbReg, wbData);
                extraRetires++;
            end
            else
            begin
                front = expected.pop_front();
                if (wbReg != front.regNum)
                begin
                    $display("CHECK FAILED %s #%0d register: expected r%0d actual r%0d",
                             kindName(front.kind), front.seq, front.regNum, wbReg);
                    valueErrors++;
                end
                if (wbData != front.data)
                begin
                    $display("CHECK FAILED %s #%0d data: expected %08h actual %08h",
                             kindName(front.kind), front.seq, front.data, wbData);
                    valueErrors++;
                end
            end
        end
    end

    initial
    begin
        logic [31:0] inst;
        logic [2:0] kind;
        bit accepted;
        int waited;
        clk = 1'b0;
        rstN = 1'b0;
        instValid = 1'b0;
        instData = '0;
        valueErrors = 0;
        otherErrors = 0;
        extraRetires = 0;
        sawStall = 1'b0;
        timedOut = 1'b0;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = '0;
        for (int i = 0; i < 64; i++)
            modelMem[i] = '0;
        void'($urandom(25));
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        for (int n = 0; n < numInsts && !timedOut; n++)
        begin
            if ($urandom % 4 == 0)
            begin
                instValid <= 1'b0; // Idle gap on the input stream.
                repeat (1 + $urandom % 3) @(posedge clk);
            end
            makeInst(inst, kind);
            sendInst(inst, accepted);
            if (accepted)
                runModel(inst, kind, n);
            else
            begin
                $display("Timeout: instReady stayed low for %0d cycles at instruction %0d",
                         readyTimeout, n);
                otherErrors++;
                timedOut = 1'b1;
            end
        end
        instValid <= 1'b0;

        waited = 0;
        while (!timedOut && expected.size() != 0 && waited < drainTimeout)
        begin
            @(posedge clk);
            waited++;
        end
        if (expected.size() != 0)
        begin
            $display("Timeout: %0d expected retires never arrived", expected.size());
            otherErrors++;
        end
        repeat (10) @(posedge clk); // Window for stray retires.
        if (extraRetires != 0)
        begin
            $display("The core retired %0d writes that were never issued", extraRetires);
            otherErrors++;
        end
        if (!sawStall)
        begin
            $display("instReady never dropped during the run");
            otherErrors++;
        end
        if (i_dut.hazardProps.failCount != 0)
        begin
            $display("Hazard unit assertions failed %0d times", i_dut.hazardProps.failCount);
            otherErrors++;
        end

        $display("Errors: %0d total, %0d value mismatches, %0d other",
                 valueErrors + otherErrors, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/pipePkg.sv
verilog/pipeReg.sv
verilog/decodeStage.sv
verilog/hazardUnit.sv
verilog/multiplier.sv
verilog/execStage.sv
verilog/memStage.sv
verilog/pipeCore.sv
bench/hazardUnit_props.sv
bench/pipeCoreTb.sv

// ==== Bender.yml ====
package:
  name: pipe_core

sources:
  - files:
      - verilog/pipePkg.sv
      - verilog/pipeReg.sv
      - verilog/decodeStage.sv
      - verilog/hazardUnit.sv
      - verilog/multiplier.sv
      - verilog/execStage.sv
      - verilog/memStage.sv
      - verilog/pipeCore.sv
  - target: simulation
    files:
      - bench/hazardUnit_props.sv
      - bench/pipeCoreTb.sv
